// ==== source/boardman_pkg.sv ====
package boardman_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  sel_t;
    typedef logic [1:0]  lane_t;
    typedef logic [23:0] frame_addr_t;

    // frame address bit positions
    localparam int WRITE_BIT = 23;
    localparam int FIXED_BIT = 22;

    typedef enum logic {
        CMD_READ,
        CMD_WRITE
    } cmd_kind_e;

    typedef enum logic [3:0] {
        IDLE,
        ADDR2,
        ADDR1,
        ADDR0,
        RD_LEN,
        RD_BUS,
        RD_HAND,
        WR_DATA,
        WR_BUS,
        WR_DONE
    } decode_state_e;

    typedef enum logic [2:0] {
        R_IDLE,
        R_ADDR2,
        R_ADDR1,
        R_ADDR0,
        R_DATA,
        R_COUNT
    } reply_state_e;

    typedef enum logic {
        X_IDLE,
        X_CYCLE
    } exec_state_e;

endpackage

// ==== source/bm_cmd_decode.sv ====
`timescale 1ns/1ps

module bm_cmd_decode #(
    parameter int WB_ADR_W = 20
) (
    input  logic                      clk,
    input  logic                      rst_i,
    input  boardman_pkg::byte_t       rx_data_i,
    input  logic                      rx_valid_i,
    input  logic                      rx_last_i,
    input  logic                      rx_err_i,
    output logic                      rx_ready_o,
    output logic                      req_valid_o,
    output logic                      req_we_o,
    output logic [WB_ADR_W-1:0]       req_adr_o,
    output boardman_pkg::word_t       req_dat_o,
    output boardman_pkg::sel_t        req_sel_o,
    input  logic                      req_done_i,
    input  boardman_pkg::word_t       rsp_dat_i,
    output logic                      hdr_valid_o,
    output boardman_pkg::frame_addr_t hdr_addr_o,
    output boardman_pkg::cmd_kind_e   hdr_kind_o,
    input  logic                      hdr_ready_i,
    output logic                      wd_valid_o,
    output boardman_pkg::word_t       wd_dat_o,
    output boardman_pkg::lane_t       wd_first_o,
    output boardman_pkg::lane_t       wd_lastlane_o,
    output logic                      wd_final_o,
    input  logic                      wd_ready_i,
    output logic                      cnt_valid_o,
    output boardman_pkg::byte_t       cnt_o,
    input  logic                      cnt_ready_i
);
    import boardman_pkg::*;

    decode_state_e       state;
    frame_addr_t         faddr;
    frame_addr_t         next_addr;
    logic [WB_ADR_W-1:0] wadr;
    lane_t               lane;
    byte_t               rd_left;
    word_t               wr_dat;
    sel_t                wr_sel;
    byte_t               wr_cnt;
    logic                wr_last;
    logic                flush;
    logic                rx_take;
    logic                bad;
    logic                rd_fin;

    assign rx_ready_o = (state == ADDR2) || (state == ADDR1) || (state == ADDR0) ||
                        (state == RD_LEN) || (state == WR_DATA);
    assign rx_take    = rx_valid_i && rx_ready_o;
    assign next_addr  = {faddr[23:8], rx_data_i};

    // a read ends on its length byte, address bytes never end a frame
    always_comb begin
        case (state)
            RD_LEN:  bad = rx_err_i || !rx_last_i;
            WR_DATA: bad = rx_err_i;
            default: bad = rx_err_i || rx_last_i;
        endcase
    end

    // remaining bytes fit in the lanes left in this word
    assign rd_fin = (rd_left <= {6'd0, ~lane});

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state       <= IDLE;
            hdr_valid_o <= 1'b0;
            flush       <= 1'b0;
        end else begin
            if (hdr_valid_o && hdr_ready_i) hdr_valid_o <= 1'b0;
            if (rx_take && flush) begin
                // drop the rest of an aborted frame
                flush <= !rx_last_i;
            end else if (rx_take && bad) begin
                flush <= !rx_last_i;
                state <= IDLE;
            end else begin
                case (state)
                    IDLE:    state <= ADDR2;
                    ADDR2:   if (rx_take) state <= ADDR1;
                    ADDR1:   if (rx_take) state <= ADDR0;
                    ADDR0:   if (rx_take) state <= faddr[WRITE_BIT] ? WR_DATA : RD_LEN;
                    RD_LEN: begin
                        if (rx_take) begin
                            hdr_valid_o <= 1'b1;
                            state       <= RD_BUS;
                        end
                    end
                    RD_BUS:  if (req_done_i) state <= RD_HAND;
                    RD_HAND: if (wd_ready_i) state <= wd_final_o ? IDLE : RD_BUS;
                    WR_DATA: if (rx_take && (lane == 2'd3 || rx_last_i)) state <= WR_BUS;
                    WR_BUS: begin
                        if (req_done_i && wr_last) begin
                            hdr_valid_o <= 1'b1;
                            state       <= WR_DONE;
                        end else if (req_done_i) begin
                            state <= WR_DATA;
                        end
                    end
                    WR_DONE: if (cnt_ready_i) state <= IDLE;
                    default: state <= IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx_take) begin
            case (state)
                ADDR2: faddr[23:16] <= rx_data_i;
                ADDR1: faddr[15:8] <= rx_data_i;
                ADDR0: begin
                    faddr[7:0] <= rx_data_i;
                    wadr       <= next_addr[WB_ADR_W+1:2];
                    lane       <= rx_data_i[1:0];
                    wr_sel     <= '0;
                    wr_cnt     <= '0;
                end
                RD_LEN: rd_left <= rx_data_i;
                WR_DATA: begin
                    // little-endian packing from the start lane
                    wr_dat[{lane, 3'b000} +: 8] <= rx_data_i;
                    wr_sel[lane] <= 1'b1;
                    wr_cnt       <= wr_cnt + 8'd1;
                    wr_last      <= rx_last_i;
                    lane         <= lane + 2'd1;
                end
                default: ;
            endcase
        end
        if (req_done_i) begin
            if (!faddr[FIXED_BIT]) wadr <= wadr + 1'b1;
            wr_sel <= '0;
            if (state == RD_BUS) begin
                wd_first_o    <= lane;
                wd_lastlane_o <= rd_fin ? lane + rd_left[1:0] : 2'd3;
                wd_final_o    <= rd_fin;
                rd_left       <= rd_left - 8'd4 + {6'd0, lane};
                lane          <= 2'd0;
            end
        end
    end

    assign req_valid_o = (state == RD_BUS) || (state == WR_BUS);
    assign req_we_o    = (state == WR_BUS);
    assign req_adr_o   = wadr;
    assign req_dat_o   = wr_dat;
    assign req_sel_o   = (state == WR_BUS) ? wr_sel : 4'hf;

    assign hdr_addr_o  = faddr;
    assign hdr_kind_o  = cmd_kind_e'(faddr[WRITE_BIT]);
    // read data stays registered in the bus master until the next cycle
    assign wd_valid_o  = (state == RD_HAND);
    assign wd_dat_o    = rsp_dat_i;
    assign cnt_valid_o = (state == WR_DONE);
    assign cnt_o       = wr_cnt;

endmodule

// ==== source/bm_bus_execute.sv ====
`timescale 1ns/1ps

module bm_bus_execute #(
    parameter int WB_ADR_W = 20
) (
    input  logic                clk,
    input  logic                rst_i,
    input  logic                req_valid_i,
    input  logic                req_we_i,
    input  logic [WB_ADR_W-1:0] req_adr_i,
    input  boardman_pkg::word_t req_dat_i,
    input  boardman_pkg::sel_t  req_sel_i,
    output logic                req_done_o,
    output boardman_pkg::word_t rsp_dat_o,
    output logic [WB_ADR_W-1:0] wb_adr_o,
    output boardman_pkg::word_t wb_dat_o,
    input  boardman_pkg::word_t wb_dat_i,
    output boardman_pkg::sel_t  wb_sel_o,
    output logic                wb_we_o,
    output logic                wb_cyc_o,
    output logic                wb_stb_o,
    input  logic                wb_ack_i
);
    import boardman_pkg::*;

    exec_state_e state;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state <= X_IDLE;
        end else begin
            case (state)
                X_IDLE:  if (req_valid_i) state <= X_CYCLE;
                X_CYCLE: if (wb_ack_i) state <= X_IDLE;
                default: state <= X_IDLE;
            endcase
        end
    end

    // bus fields held stable for the whole cycle
    always_ff @(posedge clk) begin
        if (state == X_IDLE && req_valid_i) begin
            wb_adr_o <= req_adr_i;
            wb_dat_o <= req_dat_i;
            wb_sel_o <= req_sel_i;
            wb_we_o  <= req_we_i;
        end
        if (state == X_CYCLE && wb_ack_i) rsp_dat_o <= wb_dat_i;
    end

    assign wb_cyc_o   = (state == X_CYCLE);
    assign wb_stb_o   = (state == X_CYCLE);
    assign req_done_o = (state == X_CYCLE) && wb_ack_i;

endmodule

// ==== source/bm_reply.sv ====
`timescale 1ns/1ps

module bm_reply (
    input  logic                      clk,
    input  logic                      rst_i,
    input  logic                      hdr_valid_i,
    input  boardman_pkg::frame_addr_t hdr_addr_i,
    input  boardman_pkg::cmd_kind_e   hdr_kind_i,
    output logic                      hdr_ready_o,
    input  logic                      wd_valid_i,
    input  boardman_pkg::word_t       wd_dat_i,
    input  boardman_pkg::lane_t       wd_first_i,
    input  boardman_pkg::lane_t       wd_lastlane_i,
    input  logic                      wd_final_i,
    output logic                      wd_ready_o,
    input  logic                      cnt_valid_i,
    input  boardman_pkg::byte_t       cnt_i,
    output logic                      cnt_ready_o,
    output boardman_pkg::byte_t       tx_data_o,
    output logic                      tx_valid_o,
    output logic                      tx_last_o,
    input  logic                      tx_ready_i
);
    import boardman_pkg::*;

    reply_state_e state;
    frame_addr_t  addr_q;
    cmd_kind_e    kind_q;
    word_t        buf_dat;
    lane_t        buf_lane;
    lane_t        buf_lastlane;
    logic         buf_final;
    logic         buf_full;
    logic         take_wd;
    logic         emit;
    logic         buf_end;

    assign hdr_ready_o = (state == R_IDLE);
    // no words of the next frame while the final byte is still pending
    assign wd_ready_o  = (state == R_DATA) && !buf_full && !tx_last_o;
    assign cnt_ready_o = (state == R_COUNT) && !tx_valid_o;
    assign take_wd     = wd_valid_i && wd_ready_o;
    // next lane goes out when the output register is free
    assign emit        = (state == R_DATA) && buf_full && (!tx_valid_o || tx_ready_i);
    assign buf_end     = (buf_lane == buf_lastlane);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state      <= R_IDLE;
            tx_data_o  <= '0;
            tx_valid_o <= 1'b0;
            tx_last_o  <= 1'b0;
            buf_full   <= 1'b0;
        end else begin
            if (tx_valid_o && tx_ready_i) tx_valid_o <= 1'b0;
            case (state)
                R_IDLE: begin
                    if (hdr_valid_i) begin
                        tx_data_o  <= hdr_addr_i[23:16];
                        tx_valid_o <= 1'b1;
                        state      <= R_ADDR2;
                    end
                end
                R_ADDR2: begin
                    if (tx_ready_i) begin
                        tx_data_o  <= addr_q[15:8];
                        tx_valid_o <= 1'b1;
                        state      <= R_ADDR1;
                    end
                end
                R_ADDR1: begin
                    if (tx_ready_i) begin
                        tx_data_o  <= addr_q[7:0];
                        tx_valid_o <= 1'b1;
                        state      <= R_ADDR0;
                    end
                end
                R_ADDR0: if (tx_ready_i) state <= (kind_q == CMD_WRITE) ? R_COUNT : R_DATA;
                R_COUNT: begin
                    if (cnt_valid_i && cnt_ready_o) begin
                        tx_data_o  <= cnt_i;
                        tx_valid_o <= 1'b1;
                        tx_last_o  <= 1'b1;
                    end
                end
                R_DATA: begin
                    if (take_wd) buf_full <= 1'b1;
                    if (emit) begin
                        tx_data_o  <= buf_dat[{buf_lane, 3'b000} +: 8];
                        tx_valid_o <= 1'b1;
                        tx_last_o  <= buf_final && buf_end;
                        if (buf_end) buf_full <= 1'b0;
                    end
                end
                default: state <= R_IDLE;
            endcase
            // frame done once its last byte is taken
            if (tx_valid_o && tx_ready_i && tx_last_o) begin
                tx_last_o <= 1'b0;
                state     <= R_IDLE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_valid_i && hdr_ready_o) begin
            addr_q <= hdr_addr_i;
            kind_q <= hdr_kind_i;
        end
        if (take_wd) begin
            buf_dat      <= wd_dat_i;
            buf_lane     <= wd_first_i;
            buf_lastlane <= wd_lastlane_i;
            buf_final    <= wd_final_i;
        end else if (emit) begin
            buf_lane <= buf_lane + 2'd1;
        end
    end

endmodule

// ==== source/boardman_bridge.sv ====
`timescale 1ns/1ps

module boardman_bridge #(
    parameter int WB_ADR_W = 20
) (
    input  logic                clk,
    input  logic                rst_i,
    input  boardman_pkg::byte_t rx_data_i,
    input  logic                rx_valid_i,
    input  logic                rx_last_i,
    input  logic                rx_err_i,
    output logic                rx_ready_o,
    output boardman_pkg::byte_t tx_data_o,
    output logic                tx_valid_o,
    output logic                tx_last_o,
    input  logic                tx_ready_i,
    output logic [WB_ADR_W-1:0] wb_adr_o,
    output boardman_pkg::word_t wb_dat_o,
    input  boardman_pkg::word_t wb_dat_i,
    output boardman_pkg::sel_t  wb_sel_o,
    output logic                wb_we_o,
    output logic                wb_cyc_o,
    output logic                wb_stb_o,
    input  logic                wb_ack_i
);
    import boardman_pkg::*;

    // word requests to the bus master
    logic                req_valid;
    logic                req_we;
    logic [WB_ADR_W-1:0] req_adr;
    word_t               req_dat;
    sel_t                req_sel;
    logic                req_done;
    word_t               rsp_dat;

    // reply channels
    logic        hdr_valid;
    logic        hdr_ready;
    frame_addr_t hdr_addr;
    cmd_kind_e   hdr_kind;
    logic        wd_valid;
    logic        wd_ready;
    word_t       wd_dat;
    lane_t       wd_first;
    lane_t       wd_lastlane;
    logic        wd_final;
    logic        cnt_valid;
    logic        cnt_ready;
    byte_t       cnt;

    bm_cmd_decode #(
        .WB_ADR_W(WB_ADR_W)
    ) i_bm_cmd_decode (
        .clk, .rst_i,
        .rx_data_i, .rx_valid_i, .rx_last_i, .rx_err_i, .rx_ready_o,
        .req_valid_o(req_valid),
        .req_we_o(req_we),
        .req_adr_o(req_adr),
        .req_dat_o(req_dat),
        .req_sel_o(req_sel),
        .req_done_i(req_done),
        .rsp_dat_i(rsp_dat),
        .hdr_valid_o(hdr_valid),
        .hdr_addr_o(hdr_addr),
        .hdr_kind_o(hdr_kind),
        .hdr_ready_i(hdr_ready),
        .wd_valid_o(wd_valid),
        .wd_dat_o(wd_dat),
        .wd_first_o(wd_first),
        .wd_lastlane_o(wd_lastlane),
        .wd_final_o(wd_final),
        .wd_ready_i(wd_ready),
        .cnt_valid_o(cnt_valid),
        .cnt_o(cnt),
        .cnt_ready_i(cnt_ready)
    );

    bm_bus_execute #(
        .WB_ADR_W(WB_ADR_W)
    ) i_bm_bus_execute (
        .clk, .rst_i,
        .req_valid_i(req_valid),
        .req_we_i(req_we),
        .req_adr_i(req_adr),
        .req_dat_i(req_dat),
        .req_sel_i(req_sel),
        .req_done_o(req_done),
        .rsp_dat_o(rsp_dat),
        .wb_adr_o, .wb_dat_o, .wb_dat_i, .wb_sel_o,
        .wb_we_o, .wb_cyc_o, .wb_stb_o, .wb_ack_i
    );

    bm_reply i_bm_reply (
        .clk, .rst_i,
        .hdr_valid_i(hdr_valid),
        .hdr_addr_i(hdr_addr),
        .hdr_kind_i(hdr_kind),
        .hdr_ready_o(hdr_ready),
        .wd_valid_i(wd_valid),
        .wd_dat_i(wd_dat),
        .wd_first_i(wd_first),
        .wd_lastlane_i(wd_lastlane),
        .wd_final_i(wd_final),
        .wd_ready_o(wd_ready),
        .cnt_valid_i(cnt_valid),
        .cnt_i(cnt),
        .cnt_ready_o(cnt_ready),
        .tx_data_o, .tx_valid_o, .tx_last_o, .tx_ready_i
    );

endmodule

// ==== verif/wb_mem_model.sv ====
`timescale 1ns/1ps

module wb_mem_model #(
    parameter int ADR_W = 8
) (
    input  logic                clk,
    input  logic                rst_i,
    input  logic [ADR_W-1:0]    wb_adr_i,
    input  boardman_pkg::word_t wb_dat_i,
    output boardman_pkg::word_t wb_dat_o,
    input  boardman_pkg::sel_t  wb_sel_i,
    input  logic                wb_we_i,
    input  logic                wb_cyc_i,
    input  logic                wb_stb_i,
    output logic                wb_ack_o,
    input  logic [1:0]          delay_i
);
    import boardman_pkg::*;

    word_t      mem [0:(1<<ADR_W)-1];
    logic       busy;
    logic [1:0] wait_cnt;

    // odd multiplier, every address bit shows up in the low byte
    initial begin
        for (int a = 0; a < (1 << ADR_W); a++) begin
            mem[a] <= (word_t'(a) * 32'h0101_0193) ^ 32'hc3a5_5a3c;
        end
    end

    // delay_i extra wait states are taken when a cycle starts
    always @(posedge clk) begin
        if (rst_i) begin
            wb_ack_o <= 1'b0;
            busy     <= 1'b0;
        end else begin
            wb_ack_o <= 1'b0;
            if (wb_cyc_i && wb_stb_i && !wb_ack_o) begin
                if (!busy) begin
                    busy     <= 1'b1;
                    wait_cnt <= delay_i;
                end else if (wait_cnt != 2'd0) begin
                    wait_cnt <= wait_cnt - 2'd1;
                end else begin
                    busy     <= 1'b0;
                    wb_ack_o <= 1'b1;
                    if (wb_we_i) begin
                        for (int b = 0; b < 4; b++) begin
                            if (wb_sel_i[b]) mem[wb_adr_i][b*8 +: 8] <= wb_dat_i[b*8 +: 8];
                        end
                    end else begin
                        wb_dat_o <= mem[wb_adr_i];
                    end
                end
            end
        end
    end

endmodule

// ==== verif/boardman_bridge_tb.sv ====
`timescale 1ns/1ps

module boardman_bridge_tb;
    import boardman_pkg::*;

    localparam int ADR_W       = 8;
    localparam int MEM_WORDS   = 1 << ADR_W;
    localparam int RX_LIMIT    = 200;
    localparam int REPLY_LIMIT = 4000;

    logic             clk = 1'b0;
    logic             rst_i;
    byte_t            rx_data;
    logic             rx_valid;
    logic             rx_last;
    logic             rx_err;
    logic             rx_ready;
    byte_t            tx_data;
    logic             tx_valid;
    logic             tx_last;
    logic             tx_ready = 1'b1;
    logic [ADR_W-1:0] wb_adr;
    word_t            wb_dat_w;
    word_t            wb_dat_r;
    sel_t             wb_sel;
    logic             wb_we;
    logic             wb_cyc;
    logic             wb_stb;
    logic             wb_ack;
    logic [1:0]       ack_delay = 2'd0;
    logic             stall_en;

    logic [15:0]      lfsr_q;
    word_t            shadow [0:MEM_WORDS-1];
    byte_t            frame_q [$];
    bit               last_q [$];
    bit               err_q [$];
    byte_t            exp_data [$];
    bit               exp_last [$];
    logic [ADR_W-1:0] cyc_adr_q [$];
    sel_t             cyc_sel_q [$];
    byte_t            rnd_data [16];
    int               checks;
    int               errors;
    int               err_mark;
    int               tx_count;
    int               cyc_count;

    boardman_bridge #(
        .WB_ADR_W(ADR_W)
    ) i_boardman_bridge (
        .clk, .rst_i,
        .rx_data_i(rx_data), .rx_valid_i(rx_valid), .rx_last_i(rx_last),
        .rx_err_i(rx_err), .rx_ready_o(rx_ready),
        .tx_data_o(tx_data), .tx_valid_o(tx_valid), .tx_last_o(tx_last),
        .tx_ready_i(tx_ready),
        .wb_adr_o(wb_adr), .wb_dat_o(wb_dat_w), .wb_dat_i(wb_dat_r), .wb_sel_o(wb_sel),
        .wb_we_o(wb_we), .wb_cyc_o(wb_cyc), .wb_stb_o(wb_stb), .wb_ack_i(wb_ack)
    );

    wb_mem_model #(
        .ADR_W(ADR_W)
    ) i_wb_mem_model (
        .clk, .rst_i,
        .wb_adr_i(wb_adr), .wb_dat_i(wb_dat_w), .wb_dat_o(wb_dat_r), .wb_sel_i(wb_sel),
        .wb_we_i(wb_we), .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_ack_o(wb_ack),
        .delay_i(ack_delay)
    );

    always #5 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic rand_bit();
        lfsr_q = lfsr_next(lfsr_q);
        return lfsr_q[0];
    endfunction

    function automatic byte_t rand_byte();
        byte_t b;
        for (int i = 0; i < 8; i++) b[i] = rand_bit();
        return b;
    endfunction

    function automatic frame_addr_t make_addr(input bit we, input bit fixed,
                                              input int wadr, input int lane);
        frame_addr_t fa;
        fa = '0;
        fa[WRITE_BIT] = we;
        fa[FIXED_BIT] = fixed;
        fa[21:2] = wadr[19:0];
        fa[1:0] = lane[1:0];
        return fa;
    endfunction

    function automatic void add_byte(input byte_t d, input bit last, input bit err);
        frame_q.push_back(d);
        last_q.push_back(last);
        err_q.push_back(err);
    endfunction

    function automatic void new_frame(input frame_addr_t fa);
        frame_q.delete();
        last_q.delete();
        err_q.delete();
        add_byte(fa[23:16], 1'b0, 1'b0);
        add_byte(fa[15:8], 1'b0, 1'b0);
        add_byte(fa[7:0], 1'b0, 1'b0);
    endfunction

    // expected reply of a good frame, writes also go into the shadow memory
    function automatic void build_reply();
        frame_addr_t fa;
        int wadr;
        int lane;
        int n;
        word_t w;
        fa = {frame_q[0], frame_q[1], frame_q[2]};
        for (int i = 0; i < 3; i++) begin
            exp_data.push_back(frame_q[i]);
            exp_last.push_back(1'b0);
        end
        wadr = int'(fa[21:2]) % MEM_WORDS;
        lane = int'(fa[1:0]);
        if (fa[WRITE_BIT]) begin
            for (int i = 3; i < frame_q.size(); i++) begin
                shadow[wadr][lane*8 +: 8] = frame_q[i];
                if (lane == 3 && !fa[FIXED_BIT]) wadr = (wadr + 1) % MEM_WORDS;
                lane = (lane + 1) % 4;
            end
            exp_data.push_back(byte_t'(frame_q.size() - 3));
            exp_last.push_back(1'b1);
        end else begin
            n = int'(frame_q[3]) + 1;
            for (int i = 0; i < n; i++) begin
                w = shadow[wadr];
                exp_data.push_back(w[lane*8 +: 8]);
                exp_last.push_back(i == n - 1);
                if (lane == 3 && !fa[FIXED_BIT]) wadr = (wadr + 1) % MEM_WORDS;
                lane = (lane + 1) % 4;
            end
        end
    endfunction

    task automatic fail_timeout(input string what);
        $display("timeout at %0t ns while waiting for %s", $time, what);
        $display("Checks failed");
        $finish;
    endtask

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns %s got %02h expected %02h", $time, name, got, exp);
        end
    endtask

    task automatic check_last(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns %s got %08h expected %08h", $time, name, got, exp);
        end
    endtask

    task automatic check_sel(input string name, input sel_t got, input sel_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_adr(input string name, input logic [ADR_W-1:0] got,
                             input logic [ADR_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns %s got %02h expected %02h", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("[FAIL] %0t ns %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_mem(input int a);
        check_word($sformatf("mem[%02h]", a), i_wb_mem_model.mem[a], shadow[a]);
    endtask

    task automatic end_test(input int num, input string name);
        if (errors == err_mark) $display("test %0d %s: ok", num, name);
        else $display("test %0d %s: %0d errors", num, name, errors - err_mark);
        err_mark = errors;
    endtask

    // one byte per clock where rx_ready_o was high before the edge
    task automatic send_frame();
        int waited;
        for (int i = 0; i < frame_q.size(); i++) begin
            rx_data  <= frame_q[i];
            rx_last  <= last_q[i];
            rx_err   <= err_q[i];
            rx_valid <= 1'b1;
            waited = 0;
            @(posedge clk);
            while (!rx_ready) begin
                waited++;
                if (waited > RX_LIMIT) fail_timeout("rx_ready_o to take a frame byte");
                @(posedge clk);
            end
        end
        rx_valid <= 1'b0;
        rx_last  <= 1'b0;
        rx_err   <= 1'b0;
    endtask

    task automatic wait_reply();
        int waited;
        waited = 0;
        while (exp_data.size() != 0) begin
            @(posedge clk);
            waited++;
            if (waited > REPLY_LIMIT) fail_timeout("the reply bytes");
        end
    endtask

    task automatic run_frame();
        build_reply();
        send_frame();
        wait_reply();
    endtask

    // tx stalls and ack wait states
    always @(posedge clk) begin : stall_gen
        logic [1:0] d;
        if (stall_en) begin
            tx_ready <= rand_bit();
            d[0] = rand_bit();
            d[1] = rand_bit();
            ack_delay <= d;
        end else begin
            tx_ready  <= 1'b1;
            ack_delay <= 2'd0;
        end
    end

    always @(posedge clk) begin
        if (!rst_i && wb_cyc && wb_stb && wb_ack) begin
            cyc_count++;
            cyc_adr_q.push_back(wb_adr);
            cyc_sel_q.push_back(wb_sel);
        end
    end

    // compare every accepted reply byte in order
    always @(posedge clk) begin
        if (!rst_i && tx_valid && tx_ready) begin
            tx_count++;
            if (exp_data.size() == 0) begin
                errors++;
                $display("error at %0t ns: reply byte %02h came with no reply expected",
                         $time, tx_data);
            end else begin
                check_byte("tx_data_o", tx_data, exp_data.pop_front());
                check_last("tx_last_o", tx_last, exp_last.pop_front());
            end
        end
    end

    initial begin
        int t0;
        int c0;
        rst_i    <= 1'b1;
        rx_data  <= '0;
        rx_valid <= 1'b0;
        rx_last  <= 1'b0;
        rx_err   <= 1'b0;
        stall_en <= 1'b0;
        checks   = 0;
        errors   = 0;
        err_mark = 0;
        tx_count = 0;
        cyc_count = 0;
        lfsr_q = 16'd68;
        for (int i = 0; i < 16; i++) rnd_data[i] = rand_byte();
        repeat (2) @(posedge clk);
        rst_i <= 1'b0;
        for (int a = 0; a < MEM_WORDS; a++) shadow[a] = i_wb_mem_model.mem[a];
        @(posedge clk);

        new_frame(make_addr(1'b1, 1'b0, 'h10, 0));
        for (int i = 0; i < 4; i++) add_byte(byte_t'(8'h11 * (i + 1)), i == 3, 1'b0);
        run_frame();
        new_frame(make_addr(1'b0, 1'b0, 'h10, 0));
        add_byte(8'd3, 1'b1, 1'b0);
        run_frame();
        check_mem('h10);
        end_test(1, "aligned write then read");

        new_frame(make_addr(1'b0, 1'b0, 'h20, 2));
        add_byte(8'd5, 1'b1, 1'b0);
        run_frame();
        end_test(2, "unaligned read across words");

        cyc_adr_q.delete();
        new_frame(make_addr(1'b1, 1'b1, 'h30, 0));
        for (int i = 0; i < 8; i++) add_byte(byte_t'(8'ha0 + i), i == 7, 1'b0);
        run_frame();
        check_count("wb cycles", cyc_adr_q.size(), 2);
        if (cyc_adr_q.size() == 2) begin
            check_adr("wb_adr_o", cyc_adr_q[0], 'h30);
            check_adr("wb_adr_o", cyc_adr_q[1], 'h30);
        end
        check_mem('h30);
        end_test(3, "fixed address write");

        t0 = tx_count;
        c0 = cyc_count;
        // error flag on the second address byte
        new_frame(make_addr(1'b0, 1'b0, 'h40, 1));
        err_q[1] = 1'b1;
        add_byte(8'd0, 1'b1, 1'b0);
        send_frame();
        // length byte without last, the frame ends one byte later
        new_frame(make_addr(1'b0, 1'b0, 'h40, 1));
        add_byte(8'd0, 1'b0, 1'b0);
        add_byte(8'h5a, 1'b1, 1'b0);
        send_frame();
        new_frame(make_addr(1'b0, 1'b0, 'h40, 1));
        add_byte(8'd0, 1'b1, 1'b0);
        run_frame();
        check_count("wb cycles", cyc_count - c0, 1);
        check_count("reply bytes", tx_count - t0, 4);
        end_test(4, "aborted frames");

        stall_en <= 1'b1;
        new_frame(make_addr(1'b1, 1'b0, 'h50, 1));
        for (int i = 0; i < 16; i++) add_byte(rnd_data[i], i == 15, 1'b0);
        run_frame();
        new_frame(make_addr(1'b0, 1'b0, 'h50, 1));
        add_byte(8'd15, 1'b1, 1'b0);
        run_frame();
        stall_en <= 1'b0;
        for (int a = 'h50; a <= 'h54; a++) check_mem(a);
        end_test(5, "random data under stalls");

        cyc_sel_q.delete();
        new_frame(make_addr(1'b1, 1'b0, 'h60, 1));
        for (int i = 0; i < 3; i++) add_byte(byte_t'(8'hc1 + i), i == 2, 1'b0);
        run_frame();
        check_count("wb cycles", cyc_sel_q.size(), 1);
        if (cyc_sel_q.size() == 1) check_sel("wb_sel_o", cyc_sel_q[0], 4'b1110);
        check_byte("mem[60] lane 0", i_wb_mem_model.mem['h60][7:0], shadow['h60][7:0]);
        check_mem('h60);
        end_test(6, "partial write from lane 1");

        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== boardman_bridge.f ====
source/boardman_pkg.sv
source/bm_cmd_decode.sv
source/bm_bus_execute.sv
source/bm_reply.sv
source/boardman_bridge.sv
verif/wb_mem_model.sv
verif/boardman_bridge_tb.sv

// ==== Bender.yml ====
package:
  name: boardman_bridge

sources:
  - source/boardman_pkg.sv
  - source/bm_cmd_decode.sv
  - source/bm_bus_execute.sv
  - source/bm_reply.sv
  - source/boardman_bridge.sv
  - target: simulation
    files:
      - verif/wb_mem_model.sv
      - verif/boardman_bridge_tb.sv
